// File: src/memarb_pkg.sv
package memarb_pkg;

  // --------------------------------------------------------------------------
  // widths
  // --------------------------------------------------------------------------
  localparam int ADDR_W     = 24;  // requester address, also rom bus
  localparam int RAM_ADDR_W = 19;  // save ram pins
  localparam int DATA_W     = 8;   // both buses byte wide
  localparam int WINDOW_W   = ADDR_W - RAM_ADDR_W;

  // --------------------------------------------------------------------------
  // channel and requester indices
  // --------------------------------------------------------------------------
  localparam int NUM_CH  = 2;
  localparam int CH_ROM  = 0;
  localparam int CH_RAM  = 1;

  localparam int REQ_MCU = 0;
  localparam int REQ_COP = 1;  // wins over mcu on the same bus

  // top five address bits that select the save ram
  localparam logic [WINDOW_W-1:0] RAM_WINDOW = 5'b11100;

  // --------------------------------------------------------------------------
  // requester address
  // --------------------------------------------------------------------------
  // window view splits off the bus select prefix
  typedef struct packed {
    logic [WINDOW_W-1:0]   window;
    logic [RAM_ADDR_W-1:0] offset;  // byte offset into save ram
  } mem_addr_win_t;

  // same 24 bits seen either through the window or as a flat rom address
  typedef union packed {
    mem_addr_win_t     win;
    logic [ADDR_W-1:0] flat;
  } mem_addr_u;

endpackage

// File: src/req_router.sv
`timescale 1ns/100ps

module req_router (
  input  logic                                                      CLK2,
  input  logic                                                      rst_n,
  input  logic                                                      mcu_rd,
  input  logic                                                      mcu_wr,
  input  memarb_pkg::mem_addr_u                                     mcu_addr,
  input  logic [memarb_pkg::DATA_W-1:0]                             mcu_wdata,
  input  logic                                                      cop_rd,
  input  logic                                                      cop_wr,
  input  memarb_pkg::mem_addr_u                                     cop_addr,
  input  logic [memarb_pkg::DATA_W-1:0]                             cop_wdata,
  input  logic [memarb_pkg::ADDR_W-1:0]                             rom_mask,
  input  logic                                                      mcu_ready,
  input  logic                                                      cop_ready,
  output logic [memarb_pkg::NUM_CH-1:0][1:0]                        ch_req,
  output logic [memarb_pkg::NUM_CH-1:0][1:0]                        ch_we,
  output logic [memarb_pkg::NUM_CH-1:0][1:0][memarb_pkg::ADDR_W-1:0] ch_addr,
  output logic [memarb_pkg::NUM_CH-1:0][1:0][memarb_pkg::DATA_W-1:0] ch_wdata
);
  import memarb_pkg::*;

  logic [1:0]              rd;
  logic [1:0]              wr;
  logic [1:0]              rdy;
  logic [1:0]              to_ram;    // window hit per requester
  mem_addr_u [1:0]         addr;
  logic [1:0][DATA_W-1:0]  wdata;
  logic [1:0][ADDR_W-1:0]  rom_addr;  // masked flat address
  logic [1:0][ADDR_W-1:0]  ram_addr;  // zero extended offset

  // gather the loose requester ports so both are handled alike
  assign rd[REQ_MCU]    = mcu_rd;
  assign rd[REQ_COP]    = cop_rd;
  assign wr[REQ_MCU]    = mcu_wr;
  assign wr[REQ_COP]    = cop_wr;
  assign rdy[REQ_MCU]   = mcu_ready;
  assign rdy[REQ_COP]   = cop_ready;
  assign addr[REQ_MCU]  = mcu_addr;
  assign addr[REQ_COP]  = cop_addr;
  assign wdata[REQ_MCU] = mcu_wdata;
  assign wdata[REQ_COP] = cop_wdata;

  // --------------------------------------------------------------------------
  // address decode
  // --------------------------------------------------------------------------
  always_comb begin
    for (int r = 0; r < 2; r++) begin
      to_ram[r]   = (addr[r].win.window == RAM_WINDOW);
      rom_addr[r] = addr[r].flat & rom_mask;
      ram_addr[r] = ADDR_W'(addr[r].win.offset);  // pins only see low bits
    end
  end

  // --------------------------------------------------------------------------
  // registered channel strobes
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      ch_req <= '0;
    end else begin
      for (int r = 0; r < 2; r++) begin
        ch_req[CH_ROM][r] <= (rd[r] | wr[r]) & ~to_ram[r];
        ch_req[CH_RAM][r] <= (rd[r] | wr[r]) & to_ram[r];
      end
    end
  end

  // payload follows the strobe, only loaded when something is issued
  always_ff @(posedge CLK2) begin
    for (int r = 0; r < 2; r++) begin
      if (rd[r] | wr[r]) begin
        for (int c = 0; c < NUM_CH; c++) begin
          ch_we[c][r]    <= wr[r];
          ch_wdata[c][r] <= wdata[r];
        end
        ch_addr[CH_ROM][r] <= rom_addr[r];
        ch_addr[CH_RAM][r] <= ram_addr[r];
      end
    end
  end

  // requester protocol, ready comes back from resp_merge
  for (genvar r = 0; r < 2; r++) begin : g_proto
    a_strobe_ready: assert property (@(posedge CLK2) disable iff (!rst_n)
      (rd[r] || wr[r]) |-> rdy[r]);
    a_rd_wr_excl: assert property (@(posedge CLK2) disable iff (!rst_n)
      !(rd[r] && wr[r]));
  end

endmodule

// File: src/mem_channel.sv
`timescale 1ns/100ps

module mem_channel #(
  parameter int CYCLE_LEN = 7
) (
  input  logic                                     CLK2,
  input  logic                                     rst_n,
  input  logic [1:0]                               req,
  input  logic [1:0]                               we,
  input  logic [1:0][memarb_pkg::ADDR_W-1:0]       addr,
  input  logic [1:0][memarb_pkg::DATA_W-1:0]       wdata,
  input  logic [memarb_pkg::DATA_W-1:0]            bus_rdata,
  output logic [1:0]                               busy,
  output logic [1:0]                               done,
  output logic [memarb_pkg::DATA_W-1:0]            rdata,
  output logic [memarb_pkg::ADDR_W-1:0]            bus_addr,
  output logic [memarb_pkg::DATA_W-1:0]            bus_wdata,
  output logic                                     bus_we_n
);
  import memarb_pkg::*;

  localparam int CNT_W = $clog2(CYCLE_LEN + 1);

  // one-hot sequencer states
  localparam logic [2:0] ST_IDLE = 3'b001;
  localparam logic [2:0] ST_ADDR = 3'b010;
  localparam logic [2:0] ST_END  = 3'b100;

  logic [2:0]             state;
  logic [CNT_W-1:0]       delay;      // address cycles left
  logic                   gnt;        // requester owning the bus
  logic                   last_addr;  // final address cycle

  logic [1:0]             pend;
  logic [1:0]             pend_we;
  logic [1:0][ADDR_W-1:0] pend_addr;
  logic [1:0][DATA_W-1:0] pend_wdata;

  assign last_addr = (state == ST_ADDR) && (delay == '0);

  // --------------------------------------------------------------------------
  // request capture
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      pend <= '0;
    end else begin
      for (int r = 0; r < 2; r++) begin
        if (req[r]) begin
          pend[r] <= 1'b1;
        end else if (last_addr && (gnt == 1'(r))) begin
          pend[r] <= 1'b0;  // drops as the end state starts
        end
      end
    end
  end

  always_ff @(posedge CLK2) begin
    for (int r = 0; r < 2; r++) begin
      if (req[r]) begin
        pend_we[r]    <= we[r];
        pend_addr[r]  <= addr[r];
        pend_wdata[r] <= wdata[r];
      end
    end
  end

  // --------------------------------------------------------------------------
  // bus sequencer
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      delay <= '0;
      gnt   <= 1'(REQ_MCU);
    end else begin
      case (state)
        ST_IDLE: begin
          if (pend[REQ_COP]) begin  // coprocessor first
            gnt   <= 1'(REQ_COP);
            delay <= CNT_W'(CYCLE_LEN);
            state <= ST_ADDR;
          end else if (pend[REQ_MCU]) begin
            gnt   <= 1'(REQ_MCU);
            delay <= CNT_W'(CYCLE_LEN);
            state <= ST_ADDR;
          end
        end
        ST_ADDR: begin
          delay <= delay - 1'b1;
          if (delay == '0) begin
            state <= ST_END;
          end
        end
        ST_END: state <= ST_IDLE;  // one turnaround cycle
        default: state <= ST_IDLE;
      endcase
    end
  end

  // read data settles late, keep resampling until the last address cycle
  always_ff @(posedge CLK2) begin
    if ((state == ST_ADDR) && !pend_we[gnt]) begin
      rdata <= bus_rdata;
    end
  end

  // --------------------------------------------------------------------------
  // pins and status
  // --------------------------------------------------------------------------
  assign bus_addr  = pend_addr[gnt];   // held while in address state
  assign bus_wdata = pend_wdata[gnt];
  assign bus_we_n  = ~((state == ST_ADDR) & pend_we[gnt]);

  always_comb begin
    for (int r = 0; r < 2; r++) begin
      busy[r] = req[r] | pend[r];
      // only reads report back, writes finish through busy alone
      done[r] = (state == ST_END) && (gnt == 1'(r)) && !pend_we[r];
    end
  end

  a_state_onehot: assert property (@(posedge CLK2) disable iff (!rst_n)
    $onehot(state));

  // owner keeps its request open for the whole bus cycle
  a_gnt_pending: assert property (@(posedge CLK2) disable iff (!rst_n)
    (state == ST_ADDR) |-> pend[gnt]);

endmodule

// File: src/resp_merge.sv
`timescale 1ns/100ps

module resp_merge (
  input  logic                                              CLK2,
  input  logic                                              rst_n,
  input  logic [memarb_pkg::NUM_CH-1:0][1:0]                ch_busy,
  input  logic [memarb_pkg::NUM_CH-1:0][1:0]                ch_done,
  input  logic [memarb_pkg::NUM_CH-1:0][memarb_pkg::DATA_W-1:0] ch_rdata,
  output logic                                              mcu_ready,
  output logic [memarb_pkg::DATA_W-1:0]                     mcu_rdata,
  output logic                                              cop_ready,
  output logic [memarb_pkg::DATA_W-1:0]                     cop_rdata
);
  import memarb_pkg::*;

  logic [1:0]             busy_any;  // requester busy on some bus
  logic [1:0]             ready_q;
  logic [1:0][DATA_W-1:0] rdata_q;

  always_comb begin
    busy_any = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      busy_any = busy_any | ch_busy[c];
    end
  end

  // ready rises one cycle after the bus is released
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      ready_q <= '1;
    end else begin
      ready_q <= ~busy_any;
    end
  end

  always_ff @(posedge CLK2) begin
    for (int c = 0; c < NUM_CH; c++) begin
      for (int r = 0; r < 2; r++) begin
        if (ch_done[c][r]) begin
          rdata_q[r] <= ch_rdata[c];
        end
      end
    end
  end

  // falls right away on a new channel strobe, rises from the register
  assign mcu_ready = ready_q[REQ_MCU] & ~busy_any[REQ_MCU];
  assign cop_ready = ready_q[REQ_COP] & ~busy_any[REQ_COP];
  assign mcu_rdata = rdata_q[REQ_MCU];
  assign cop_rdata = rdata_q[REQ_COP];

  // --------------------------------------------------------------------------
  // a requester has one access in flight, so at most one bus completes it
  // --------------------------------------------------------------------------
  for (genvar r = 0; r < 2; r++) begin : g_chk
    logic [NUM_CH-1:0] done_r;

    always_comb begin
      for (int c = 0; c < NUM_CH; c++) begin
        done_r[c] = ch_done[c][r];
      end
    end

    a_one_done: assert property (@(posedge CLK2) disable iff (!rst_n)
      $onehot0(done_r));
  end

endmodule

// File: src/memarb_top.sv
`timescale 1ns/100ps

module memarb_top #(
  parameter int ROM_CYCLE_LEN = 7,
  parameter int RAM_CYCLE_LEN = 5
) (
  input  logic                              CLK2,
  input  logic                              rst_n,

  // mcu requester
  input  logic                              mcu_rd,
  input  logic                              mcu_wr,
  input  logic [memarb_pkg::ADDR_W-1:0]     mcu_addr,
  input  logic [memarb_pkg::DATA_W-1:0]     mcu_wdata,
  output logic                              mcu_ready,
  output logic [memarb_pkg::DATA_W-1:0]     mcu_rdata,

  // coprocessor requester
  input  logic                              cop_rd,
  input  logic                              cop_wr,
  input  logic [memarb_pkg::ADDR_W-1:0]     cop_addr,
  input  logic [memarb_pkg::DATA_W-1:0]     cop_wdata,
  output logic                              cop_ready,
  output logic [memarb_pkg::DATA_W-1:0]     cop_rdata,

  input  logic [memarb_pkg::ADDR_W-1:0]     rom_mask,

  // external memories
  output logic [memarb_pkg::ADDR_W-1:0]     rom_addr,
  output logic [memarb_pkg::DATA_W-1:0]     rom_wdata,
  output logic                              rom_we_n,
  input  logic [memarb_pkg::DATA_W-1:0]     rom_rdata,
  output logic [memarb_pkg::RAM_ADDR_W-1:0] ram_addr,
  output logic [memarb_pkg::DATA_W-1:0]     ram_wdata,
  output logic                              ram_we_n,
  input  logic [memarb_pkg::DATA_W-1:0]     ram_rdata
);
  import memarb_pkg::*;

  logic [NUM_CH-1:0][1:0]             ch_req;
  logic [NUM_CH-1:0][1:0]             ch_we;
  logic [NUM_CH-1:0][1:0][ADDR_W-1:0] ch_addr;
  logic [NUM_CH-1:0][1:0][DATA_W-1:0] ch_wdata;
  logic [NUM_CH-1:0][1:0]             ch_busy;
  logic [NUM_CH-1:0][1:0]             ch_done;
  logic [NUM_CH-1:0][DATA_W-1:0]      ch_rdata;

  logic [NUM_CH-1:0][ADDR_W-1:0]      bus_addr;
  logic [NUM_CH-1:0][DATA_W-1:0]      bus_wdata;
  logic [NUM_CH-1:0]                  bus_we_n;
  logic [NUM_CH-1:0][DATA_W-1:0]      bus_rdata;

  req_router i_router (
    .CLK2      (CLK2),
    .rst_n     (rst_n),
    .mcu_rd    (mcu_rd),
    .mcu_wr    (mcu_wr),
    .mcu_addr  (mcu_addr),
    .mcu_wdata (mcu_wdata),
    .cop_rd    (cop_rd),
    .cop_wr    (cop_wr),
    .cop_addr  (cop_addr),
    .cop_wdata (cop_wdata),
    .rom_mask  (rom_mask),
    .mcu_ready (mcu_ready),
    .cop_ready (cop_ready),
    .ch_req    (ch_req),
    .ch_we     (ch_we),
    .ch_addr   (ch_addr),
    .ch_wdata  (ch_wdata)
  );

  // --------------------------------------------------------------------------
  // one sequencer per external bus
  // --------------------------------------------------------------------------
  for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
    localparam int LEN = (c == CH_RAM) ? RAM_CYCLE_LEN : ROM_CYCLE_LEN;

    mem_channel #(
      .CYCLE_LEN (LEN)
    ) i_channel (
      .CLK2      (CLK2),
      .rst_n     (rst_n),
      .req       (ch_req[c]),
      .we        (ch_we[c]),
      .addr      (ch_addr[c]),
      .wdata     (ch_wdata[c]),
      .bus_rdata (bus_rdata[c]),
      .busy      (ch_busy[c]),
      .done      (ch_done[c]),
      .rdata     (ch_rdata[c]),
      .bus_addr  (bus_addr[c]),
      .bus_wdata (bus_wdata[c]),
      .bus_we_n  (bus_we_n[c])
    );
  end

  resp_merge i_merge (
    .CLK2      (CLK2),
    .rst_n     (rst_n),
    .ch_busy   (ch_busy),
    .ch_done   (ch_done),
    .ch_rdata  (ch_rdata),
    .mcu_ready (mcu_ready),
    .mcu_rdata (mcu_rdata),
    .cop_ready (cop_ready),
    .cop_rdata (cop_rdata)
  );

  // pin split
  assign rom_addr          = bus_addr[CH_ROM];
  assign rom_wdata         = bus_wdata[CH_ROM];
  assign rom_we_n          = bus_we_n[CH_ROM];
  assign bus_rdata[CH_ROM] = rom_rdata;

  assign ram_addr          = bus_addr[CH_RAM][RAM_ADDR_W-1:0];  // upper bits always zero
  assign ram_wdata         = bus_wdata[CH_RAM];
  assign ram_we_n          = bus_we_n[CH_RAM];
  assign bus_rdata[CH_RAM] = ram_rdata;

endmodule

// File: tb/mem_model.sv
`timescale 1ns/100ps

module mem_model (
  input  logic                              CLK2,
  input  logic [memarb_pkg::ADDR_W-1:0]     rom_addr,
  input  logic [memarb_pkg::DATA_W-1:0]     rom_wdata,
  input  logic                              rom_we_n,
  output logic [memarb_pkg::DATA_W-1:0]     rom_rdata,
  input  logic [memarb_pkg::RAM_ADDR_W-1:0] ram_addr,
  input  logic [memarb_pkg::DATA_W-1:0]     ram_wdata,
  input  logic                              ram_we_n,
  output logic [memarb_pkg::DATA_W-1:0]     ram_rdata
);
  import memarb_pkg::*;

  // byte-wide arrays, preloaded by the testbench before reset ends
  logic [DATA_W-1:0] rom [0:(1<<ADDR_W)-1];
  logic [DATA_W-1:0] ram [0:(1<<RAM_ADDR_W)-1];

  assign rom_rdata = rom[rom_addr];  // asynchronous read
  assign ram_rdata = ram[ram_addr];

  // write lands at the edge while we_n is low
  always @(posedge CLK2) begin
    if (!rom_we_n) begin
      rom[rom_addr] = rom_wdata;
    end
    if (!ram_we_n) begin
      ram[ram_addr] = ram_wdata;
    end
  end

endmodule

// File: tb/tb_memarb.sv
`timescale 1ns/100ps

module tb_memarb;
  import memarb_pkg::*;

  localparam int NUM_OPS   = 100;  // per requester in the random phase
  localparam int TIMEOUT   = 200;  // cycles per wait
  localparam int ROM_CYCLE = 7;
  localparam int RAM_CYCLE = 5;
  localparam logic [ADDR_W-1:0] FULL_MASK = '1;

  logic              CLK2;
  logic              rst_n;
  logic              req_rd    [2];
  logic              req_wr    [2];
  logic [ADDR_W-1:0] req_addr  [2];
  logic [DATA_W-1:0] req_wdata [2];
  logic              req_ready [2];
  logic [DATA_W-1:0] req_rdata [2];
  logic [ADDR_W-1:0] rom_mask;

  logic [ADDR_W-1:0]     rom_addr;
  logic [DATA_W-1:0]     rom_wdata;
  logic                  rom_we_n;
  logic [DATA_W-1:0]     rom_rdata;
  logic [RAM_ADDR_W-1:0] ram_addr;
  logic [DATA_W-1:0]     ram_wdata;
  logic                  ram_we_n;
  logic [DATA_W-1:0]     ram_rdata;

  logic [DATA_W-1:0] shadow_rom [0:(1<<ADDR_W)-1];
  logic [DATA_W-1:0] shadow_ram [0:(1<<RAM_ADDR_W)-1];

  // completed reads waiting for the compare process
  logic [DATA_W-1:0] got_q [$];
  logic [DATA_W-1:0] exp_q [$];
  string             tag_q [$];

  memarb_top i_dut (
    .CLK2 (CLK2), .rst_n (rst_n),
    .mcu_rd (req_rd[REQ_MCU]), .mcu_wr (req_wr[REQ_MCU]),
    .mcu_addr (req_addr[REQ_MCU]), .mcu_wdata (req_wdata[REQ_MCU]),
    .mcu_ready (req_ready[REQ_MCU]), .mcu_rdata (req_rdata[REQ_MCU]),
    .cop_rd (req_rd[REQ_COP]), .cop_wr (req_wr[REQ_COP]),
    .cop_addr (req_addr[REQ_COP]), .cop_wdata (req_wdata[REQ_COP]),
    .cop_ready (req_ready[REQ_COP]), .cop_rdata (req_rdata[REQ_COP]),
    .rom_mask (rom_mask),
    .rom_addr (rom_addr), .rom_wdata (rom_wdata), .rom_we_n (rom_we_n), .rom_rdata (rom_rdata),
    .ram_addr (ram_addr), .ram_wdata (ram_wdata), .ram_we_n (ram_we_n), .ram_rdata (ram_rdata)
  );

  mem_model i_mem (
    .CLK2 (CLK2),
    .rom_addr (rom_addr), .rom_wdata (rom_wdata), .rom_we_n (rom_we_n), .rom_rdata (rom_rdata),
    .ram_addr (ram_addr), .ram_wdata (ram_wdata), .ram_we_n (ram_we_n), .ram_rdata (ram_rdata)
  );

  initial begin
    CLK2 = 1'b0;
    forever #5 CLK2 = ~CLK2;
  end

  // --------------------------------------------------------------------------
  // reference model
  // --------------------------------------------------------------------------
  function automatic logic [DATA_W-1:0] rom_fill(logic [ADDR_W-1:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5a;
  endfunction

  function automatic logic [DATA_W-1:0] ram_fill(logic [RAM_ADDR_W-1:0] a);
    return a[7:0] ^ a[15:8] ^ {5'b0, a[18:16]} ^ 8'ha5;
  endfunction

  function automatic logic [DATA_W-1:0] expected_read(mem_addr_u a, logic [ADDR_W-1:0] mask);
    if (a.win.window == RAM_WINDOW) begin
      return shadow_ram[a.win.offset];
    end else begin
      return shadow_rom[a.flat & mask];  // high bits alias under a reduced mask
    end
  endfunction

  function automatic void shadow_write(mem_addr_u a, logic [ADDR_W-1:0] mask,
                                       logic [DATA_W-1:0] d);
    if (a.win.window == RAM_WINDOW) begin
      shadow_ram[a.win.offset] = d;
    end else begin
      shadow_rom[a.flat & mask] = d;
    end
  endfunction

  function automatic string requester_name(int r);
    return (r == REQ_MCU) ? "mcu" : "cop";
  endfunction

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check(logic [31:0] got, logic [31:0] exp, string what);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH at %0t ns: %s got %0h expected %0h",
                         $time, what, got, exp));
    end
  endtask

  // --------------------------------------------------------------------------
  // requester handshake entered 1 ns after a rising edge
  // --------------------------------------------------------------------------
  task automatic wait_ready(int r, output int cycles);
    cycles = 0;
    while (!req_ready[r]) begin
      @(posedge CLK2);
      #1;
      cycles++;
      if (cycles > TIMEOUT) begin
        fail_run($sformatf("%s ready never returned within %0d cycles",
                           requester_name(r), TIMEOUT));
      end
    end
  endtask

  task automatic access(int r, bit write, logic [ADDR_W-1:0] addr,
                        logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata,
                        output int latency);
    logic [DATA_W-1:0] exp;
    int                idle;
    wait_ready(r, idle);
    exp          = expected_read(addr, rom_mask);
    req_rd[r]    = !write;
    req_wr[r]    = write;
    req_addr[r]  = addr;
    req_wdata[r] = wdata;
    @(posedge CLK2);  // strobe taken here
    #1;
    req_rd[r] = 1'b0;
    req_wr[r] = 1'b0;
    if (write) begin
      shadow_write(addr, rom_mask, wdata);
    end
    wait_ready(r, latency);
    rdata = req_rdata[r];
    if (!write) begin
      got_q.push_back(rdata);
      exp_q.push_back(exp);
      tag_q.push_back($sformatf("%s read %06h", requester_name(r), addr));
    end
  endtask

  task automatic random_traffic(int r);
    logic [31:0]       rnd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] rdata;
    int                lat;
    for (int i = 0; i < NUM_OPS; i++) begin
      rnd  = $urandom();
      addr = {rnd[23:19], 13'h0, rnd[5:0]};  // small pool so reads hit writes
      if (rnd[31]) begin
        addr[ADDR_W-1 -: WINDOW_W] = RAM_WINDOW;
      end else if (addr[ADDR_W-1 -: WINDOW_W] == RAM_WINDOW) begin
        addr[ADDR_W-1] = 1'b0;  // stay on rom
      end
      addr[0] = r[0];  // each requester owns one parity
      rnd = $urandom();
      access(r, rnd[1:0] == 2'b00, addr, rnd[15:8], rdata, lat);
      repeat (rnd[17:16]) begin
        @(posedge CLK2);
        #1;
      end
    end
  endtask

  // compare process
  always @(posedge CLK2) begin
    while (got_q.size() > 0) begin
      check(32'(got_q.pop_front()), 32'(exp_q.pop_front()), tag_q.pop_front());
    end
  end

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin
    logic [DATA_W-1:0] rd_a;
    logic [DATA_W-1:0] rd_b;
    int                lat;
    void'($urandom(77));
    rst_n    = 1'b0;
    rom_mask = FULL_MASK;
    for (int r = 0; r < 2; r++) begin
      req_rd[r]    = 1'b0;
      req_wr[r]    = 1'b0;
      req_addr[r]  = '0;
      req_wdata[r] = '0;
    end
    for (int a = 0; a < (1 << ADDR_W); a++) begin
      shadow_rom[ADDR_W'(a)] = rom_fill(ADDR_W'(a));
      i_mem.rom[ADDR_W'(a)]  = shadow_rom[ADDR_W'(a)];
    end
    for (int a = 0; a < (1 << RAM_ADDR_W); a++) begin
      shadow_ram[RAM_ADDR_W'(a)] = ram_fill(RAM_ADDR_W'(a));
      i_mem.ram[RAM_ADDR_W'(a)]  = shadow_ram[RAM_ADDR_W'(a)];
    end
    repeat (4) @(posedge CLK2);
    #1;
    rst_n = 1'b1;

    check(32'(req_ready[REQ_MCU]), 32'd1, "mcu_ready after reset");
    check(32'(req_ready[REQ_COP]), 32'd1, "cop_ready after reset");
    check(32'(rom_we_n), 32'd1, "rom_we_n after reset");
    check(32'(ram_we_n), 32'd1, "ram_we_n after reset");

    // uncontended latency is the cycle length plus four
    access(REQ_MCU, 1'b0, 24'h012345, 8'h00, rd_a, lat);
    check(32'(lat), 32'(ROM_CYCLE + 4), "rom read latency");
    access(REQ_MCU, 1'b0, {RAM_WINDOW, 19'h01234}, 8'h00, rd_a, lat);
    check(32'(lat), 32'(RAM_CYCLE + 4), "ram read latency");

    // write then read back on both windows
    access(REQ_MCU, 1'b1, 24'h2a0010, 8'hc3, rd_a, lat);
    rom_mask = 24'h0fffff;  // a ram write leaking onto rom would land at 040010
    access(REQ_MCU, 1'b1, {RAM_WINDOW, 19'h40010}, 8'h3c, rd_a, lat);
    rom_mask = FULL_MASK;
    access(REQ_MCU, 1'b0, 24'h2a0010, 8'h00, rd_a, lat);
    check(32'(rd_a), 32'hc3, "rom write readback");
    access(REQ_MCU, 1'b0, {RAM_WINDOW, 19'h40010}, 8'h00, rd_a, lat);
    check(32'(rd_a), 32'h3c, "ram write readback");
    access(REQ_MCU, 1'b0, 24'h040010, 8'h00, rd_a, lat);  // rom at the ram offset
    check(32'(rd_a), 32'(rom_fill(24'h040010)), "rom untouched by ram write");

    // reduced mask folds bits 21:20 away
    rom_mask = 24'h0fffff;
    access(REQ_MCU, 1'b0, 24'h0a1234, 8'h00, rd_a, lat);
    access(REQ_MCU, 1'b0, 24'h3a1234, 8'h00, rd_b, lat);
    check(32'(rd_b), 32'(rom_fill(24'h0a1234)), "rom mask alias");
    rom_mask = FULL_MASK;

    fork
      random_traffic(REQ_MCU);
      random_traffic(REQ_COP);
    join

    for (int i = 0; (i < TIMEOUT) && (got_q.size() > 0); i++) begin
      @(posedge CLK2);
      #1;
    end
    if (got_q.size() == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      fail_run("completed reads were never compared");
    end
  end

endmodule

// File: compile.f
src/memarb_pkg.sv
src/req_router.sv
src/mem_channel.sv
src/resp_merge.sv
src/memarb_top.sv
tb/mem_model.sv
tb/tb_memarb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_memarb -f compile.f

status=0
out=$(./obj_dir/Vtb_memarb 2>&1) || status=$?
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q '^Verification passed$'; then
  exit 0
fi
echo "simulation did not pass (exit status $status)"
exit 1
